// File: hw/ics_periph_defs.svh
/*
 * Peripheral address map
 * Region field position, region codes and register reset values.
 */

`ifndef ICS_PERIPH_DEFS_SVH
`define ICS_PERIPH_DEFS_SVH

// region field, in byte address bits
`define ICS_REGION_MSB 19
`define ICS_REGION_LSB 16

// region codes, anything else is unmapped
`define ICS_REGION_STATUS 4'h0
`define ICS_REGION_DSP    4'h1
`define ICS_REGION_PAD    4'h2
`define ICS_REGION_COP    4'h3

// led_r on, led_b off
`define ICS_STATUS_RESET 2'b01

// byte address bit that selects multiplier operand b
`define ICS_DSP_SEL_BIT 2

`endif

// File: hw/ics_periph_pkg.sv
/*
 * Peripheral subsystem types
 * Vector widths for the Wishbone host bus, the multiplier and the copper RAM,
 * plus the state encoding of the bus controller.
 */

`default_nettype none

package ics_periph_pkg;

    // word address, stands for byte address bits 23:2
    typedef logic [21:0] bus_addr_t;

    typedef logic [31:0] bus_data_t;

    typedef logic [3:0] bus_sel_t;

    // multiplier operands and product are signed
    typedef logic signed [15:0] mult_operand_t;

    typedef logic signed [31:0] mult_result_t;

    // halfword address into the 2048 entry copper RAM
    typedef logic [10:0] cop_addr_t;

    typedef logic [15:0] cop_data_t;

    // bus controller states
    typedef enum logic {
        bus_idle,
        bus_ack
    } bus_state_t;

endpackage

`default_nettype wire

// File: hw/periph_bus_ctrl.sv
/*
 * Peripheral bus controller
 * Wishbone classic slave: decodes the region field, issues one-cycle write
 * enables, returns a registered read mux with a single ack and holds the
 * status register that drives the LEDs.
 */

`timescale 1ns/100ps
`default_nettype none

`include "ics_periph_defs.svh"

module periph_bus_ctrl (
    input  wire                        vdp_clk,
    input  wire                        vdp_reset,

    input  wire                        wb_cyc,
    input  wire                        wb_stb,
    input  wire                        wb_we,
    input  ics_periph_pkg::bus_addr_t  wb_adr,
    input  ics_periph_pkg::bus_sel_t   wb_sel,
    input  ics_periph_pkg::bus_data_t  wb_dat_i,
    output ics_periph_pkg::bus_data_t  wb_dat_o,
    output logic                       wb_ack,

    input  ics_periph_pkg::mult_result_t dsp_result,
    input  wire                        pad_data,

    output logic                       dsp_write_en,
    output logic                       dsp_sel_b,
    output logic                       pad_write_en,
    output logic                       cop_write_en,
    output ics_periph_pkg::cop_addr_t  cop_write_address,
    output logic [15:0]                write_data,

    output logic                       led_r,
    output logic                       led_b
);

    ics_periph_pkg::bus_state_t state;
    logic [`ICS_REGION_MSB - `ICS_REGION_LSB:0] region;
    logic request;
    logic write_request;
    logic status_write_en;
    logic [1:0] status;
    ics_periph_pkg::bus_data_t read_mux;

    // wb_adr is a word address, so byte bit n sits at index n - 2
    assign region = wb_adr[`ICS_REGION_MSB - 2:`ICS_REGION_LSB - 2];

    // a request is only accepted from idle, so every enable lasts one cycle
    assign request = (state == ics_periph_pkg::bus_idle) && wb_cyc && wb_stb;
    assign write_request = request && wb_we;

    assign status_write_en = write_request && (region == `ICS_REGION_STATUS);
    assign dsp_write_en = write_request && (region == `ICS_REGION_DSP);
    assign pad_write_en = write_request && (region == `ICS_REGION_PAD);
    assign cop_write_en = write_request && (region == `ICS_REGION_COP);

    assign dsp_sel_b = wb_adr[`ICS_DSP_SEL_BIT - 2];

    // odd halfword slot when the upper halfword lane is selected
    assign cop_write_address = {wb_adr[9:0], wb_sel[2]};

    assign write_data = wb_dat_i[15:0];

    always_comb begin
        case (region)
            `ICS_REGION_STATUS: read_mux = {30'b0, status};
            `ICS_REGION_DSP: read_mux = dsp_result;
            `ICS_REGION_PAD: read_mux = {31'b0, pad_data};
            default: read_mux = '0;
        endcase
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            state <= ics_periph_pkg::bus_idle;
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= request;

            case (state)
                ics_periph_pkg::bus_idle: begin
                    if (request) begin
                        state <= ics_periph_pkg::bus_ack;
                    end
                end
                ics_periph_pkg::bus_ack: begin
                    // wait for stb to fall so a slow master gets no second ack
                    if (!(wb_cyc && wb_stb)) begin
                        state <= ics_periph_pkg::bus_idle;
                    end
                end
                default: state <= ics_periph_pkg::bus_idle;
            endcase
        end
    end

    // read data lands together with ack
    always_ff @(posedge vdp_clk) begin
        if (request) begin
            wb_dat_o <= read_mux;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= `ICS_STATUS_RESET;
        end else if (status_write_en) begin
            status <= wb_dat_i[1:0];
        end
    end

    assign led_r = status[0];
    assign led_b = status[1];

endmodule

`default_nettype wire

// File: hw/dsp_mult.sv
/*
 * Signed multiplier helper
 * Two host-written 16-bit operands and a registered 32-bit signed product.
 */

`timescale 1ns/100ps
`default_nettype none

`include "ics_periph_defs.svh"

module dsp_mult (
    input  wire                            vdp_clk,

    input  wire                            write_en,
    input  wire                            sel_b,
    input  ics_periph_pkg::mult_operand_t  write_data,

    output ics_periph_pkg::mult_result_t   result
);

    ics_periph_pkg::mult_operand_t mult_a;
    ics_periph_pkg::mult_operand_t mult_b;

    // flat operand loads keep these registers inside a MAC cell
    always_ff @(posedge vdp_clk) begin
        if (write_en && !sel_b) begin
            mult_a <= write_data;
        end

        if (write_en && sel_b) begin
            mult_b <= write_data;
        end

        // product trails an operand write by one edge
        result <= mult_a * mult_b;
    end

endmodule

`default_nettype wire

// File: hw/pad_reader.sv
/*
 * Gamepad reader
 * Control register with latch and pad clock bits; the three buttons are
 * latched into a shift register that shifts out on pad clock rising edges.
 */

`timescale 1ns/100ps
`default_nettype none

module pad_reader (
    input  wire        vdp_clk,
    input  wire        vdp_reset,

    input  wire        write_en,
    input  wire [15:0] write_data,

    input  wire        btn1,
    input  wire        btn2,
    input  wire        btn3,

    output logic       pad_data
);

    logic [1:0] pad_ctrl;
    logic pad_latch;
    logic pad_clk;
    logic pad_clk_q;
    logic [15:0] pad_shift;

    assign pad_latch = pad_ctrl[0];
    assign pad_clk = pad_ctrl[1];

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_ctrl <= 2'b00;
            pad_clk_q <= 1'b0;
        end else begin
            if (write_en) begin
                pad_ctrl <= write_data[1:0];
            end

            pad_clk_q <= pad_clk;
        end
    end

    always_ff @(posedge vdp_clk) begin
        // btn1 and btn3 are left and right, btn2 is B
        if (pad_latch) begin
            pad_shift <= {8'b0, btn1, btn3, 5'b0, btn2};
        end

        // a clock edge wins over latch
        if (pad_clk && !pad_clk_q) begin
            pad_shift <= {1'b0, pad_shift[15:1]};
        end
    end

    assign pad_data = pad_shift[0];

endmodule

`default_nettype wire

// File: hw/cop_ram.sv
/*
 * Copper RAM
 * 2048 x 16 block RAM, written from the host bus and read by the display side.
 */

`timescale 1ns/100ps
`default_nettype none

module cop_ram (
    input  wire                        vdp_clk,

    input  wire                        write_en,
    input  ics_periph_pkg::cop_addr_t  write_address,
    input  ics_periph_pkg::cop_data_t  write_data,

    input  wire                        read_en,
    input  ics_periph_pkg::cop_addr_t  read_address,
    output ics_periph_pkg::cop_data_t  read_data
);

    ics_periph_pkg::cop_data_t mem [0:2047];

    always_ff @(posedge vdp_clk) begin
        if (write_en) begin
            mem[write_address] <= write_data;
        end
    end

    // read data holds while read_en is low
    always_ff @(posedge vdp_clk) begin
        if (read_en) begin
            read_data <= mem[read_address];
        end
    end

endmodule

`default_nettype wire

// File: hw/ics_periph_top.sv
/*
 * Peripheral subsystem top
 * Wishbone controller plus multiplier, gamepad reader and copper RAM.
 */

`timescale 1ns/100ps
`default_nettype none

module ics_periph_top (
    input  wire                          vdp_clk,
    input  wire                          vdp_reset,

    input  wire                          wb_cyc,
    input  wire                          wb_stb,
    input  wire                          wb_we,
    input  ics_periph_pkg::bus_addr_t    wb_adr,
    input  ics_periph_pkg::bus_sel_t     wb_sel,
    input  ics_periph_pkg::bus_data_t    wb_dat_i,
    output ics_periph_pkg::bus_data_t    wb_dat_o,
    output wire                          wb_ack,

    output wire                          led_r,
    output wire                          led_b,

    input  wire                          btn1,
    input  wire                          btn2,
    input  wire                          btn3,

    input  wire                          cop_read_en,
    input  ics_periph_pkg::cop_addr_t    cop_read_address,
    output ics_periph_pkg::cop_data_t    cop_read_data
);

    ics_periph_pkg::mult_result_t dsp_result;
    wire pad_data;
    wire dsp_write_en;
    wire dsp_sel_b;
    wire pad_write_en;
    wire cop_write_en;
    ics_periph_pkg::cop_addr_t cop_write_address;
    wire [15:0] write_data;

    periph_bus_ctrl bus_ctrl (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_sel(wb_sel),
        .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o),
        .wb_ack(wb_ack),
        .dsp_result(dsp_result),
        .pad_data(pad_data),
        .dsp_write_en(dsp_write_en),
        .dsp_sel_b(dsp_sel_b),
        .pad_write_en(pad_write_en),
        .cop_write_en(cop_write_en),
        .cop_write_address(cop_write_address),
        .write_data(write_data),
        .led_r(led_r),
        .led_b(led_b)
    );

    dsp_mult dsp (
        .vdp_clk(vdp_clk),
        .write_en(dsp_write_en),
        .sel_b(dsp_sel_b),
        .write_data(write_data),
        .result(dsp_result)
    );

    pad_reader pad (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .write_en(pad_write_en),
        .write_data(write_data),
        .btn1(btn1),
        .btn2(btn2),
        .btn3(btn3),
        .pad_data(pad_data)
    );

    // read port goes straight out to the display engine
    cop_ram copper_ram (
        .vdp_clk(vdp_clk),
        .write_en(cop_write_en),
        .write_address(cop_write_address),
        .write_data(write_data),
        .read_en(cop_read_en),
        .read_address(cop_read_address),
        .read_data(cop_read_data)
    );

endmodule

`default_nettype wire

// File: dv/ics_periph_tb.sv
/*
 * Peripheral subsystem testbench
 * Directed tests for the status register, multiplier, gamepad reader,
 * copper RAM and unmapped regions over the Wishbone host bus.
 */

`timescale 1ns/100ps
`default_nettype none

`include "ics_periph_defs.svh"

module ics_periph_tb;

    localparam realtime clk_period = 4.0;
    localparam realtime drive_delay = 0.5;
    localparam int reset_cycles = 16;
    localparam int status_iters = 8;
    localparam int mult_iters = 20;
    localparam int pad_bits = 16;
    localparam int cop_writes = 32;
    // bus and copper port operations over all tests
    localparam int op_count = 1 + 2 * status_iters + 3 * mult_iters + 2 + 3 * pad_bits
        + 2 * cop_writes + 6;

    logic vdp_clk;
    logic vdp_reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    ics_periph_pkg::bus_addr_t wb_adr;
    ics_periph_pkg::bus_sel_t wb_sel;
    ics_periph_pkg::bus_data_t wb_dat_i;
    ics_periph_pkg::bus_data_t wb_dat_o;
    logic wb_ack;
    logic led_r;
    logic led_b;
    logic btn1;
    logic btn2;
    logic btn3;
    logic cop_read_en;
    ics_periph_pkg::cop_addr_t cop_read_address;
    ics_periph_pkg::cop_data_t cop_read_data;

    // reference state for the later checks
    ics_periph_pkg::cop_data_t cop_model [0:2047];
    ics_periph_pkg::cop_addr_t cop_addrs [0:cop_writes - 1];
    logic [1:0] last_status;
    ics_periph_pkg::mult_result_t last_product;

    ics_periph_top uut (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_sel(wb_sel),
        .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o),
        .wb_ack(wb_ack),
        .led_r(led_r),
        .led_b(led_b),
        .btn1(btn1),
        .btn2(btn2),
        .btn3(btn3),
        .cop_read_en(cop_read_en),
        .cop_read_address(cop_read_address),
        .cop_read_data(cop_read_data)
    );

    initial begin
        vdp_clk = 1'b0;
        forever #(clk_period / 2) vdp_clk = ~vdp_clk;
    end

    initial begin
        #((reset_cycles + 20 * op_count) * clk_period);
        fail_run("watchdog expired before the tests finished");
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s: got %h expected %h", name, got, expected);
            fail_run("value check failed");
        end
    endtask

    // word address from a region code and a word offset inside it
    function automatic ics_periph_pkg::bus_addr_t region_addr(input logic [3:0] region,
                                                              input logic [13:0] offset);
        ics_periph_pkg::bus_addr_t adr;
        adr = '0;
        adr[13:0] = offset;
        adr[`ICS_REGION_MSB - 2:`ICS_REGION_LSB - 2] = region;
        return adr;
    endfunction

    // all bus tasks start and end 0.5 ns after a rising edge
    task automatic wait_for_ack();
        int cycles;
        cycles = 0;
        @(posedge vdp_clk);
        #drive_delay;
        while (!wb_ack) begin
            cycles++;
            if (cycles >= 8) begin
                fail_run("wb_ack did not arrive within 8 cycles");
            end
            @(posedge vdp_clk);
            #drive_delay;
        end
    endtask

    task automatic wb_write(input ics_periph_pkg::bus_addr_t adr,
                            input ics_periph_pkg::bus_sel_t sel,
                            input ics_periph_pkg::bus_data_t data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b1;
        wb_adr = adr;
        wb_sel = sel;
        wb_dat_i = data;
        wait_for_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        // idle cycle between transfers
        @(posedge vdp_clk);
        #drive_delay;
    endtask

    task automatic wb_read(input ics_periph_pkg::bus_addr_t adr,
                           output ics_periph_pkg::bus_data_t data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b0;
        wb_adr = adr;
        wb_sel = 4'hf;
        wait_for_ack();
        data = wb_dat_o;
        // stb held one more cycle like a slow master, ack must not repeat
        @(posedge vdp_clk);
        #drive_delay;
        check_value("wb_ack one cycle after ack", wb_ack, 32'h0);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(posedge vdp_clk);
        #drive_delay;
    endtask

    task automatic cop_port_read(input ics_periph_pkg::cop_addr_t addr,
                                 output ics_periph_pkg::cop_data_t data);
        cop_read_en = 1'b1;
        cop_read_address = addr;
        @(posedge vdp_clk);
        #drive_delay;
        cop_read_en = 1'b0;
        data = cop_read_data;
    endtask

    task automatic test_status();
        ics_periph_pkg::bus_data_t rd;
        logic [1:0] v;
        check_value("led_r after reset", led_r, 32'h1);
        check_value("led_b after reset", led_b, 32'h0);
        wb_read(region_addr(`ICS_REGION_STATUS, 14'h0), rd);
        check_value("status after reset", rd, 32'h1);
        for (int i = 0; i < status_iters; i++) begin
            v = 2'($urandom_range(3));
            wb_write(region_addr(`ICS_REGION_STATUS, 14'h0), 4'hf, {30'b0, v});
            check_value("led_r", led_r, v[0]);
            check_value("led_b", led_b, v[1]);
            wb_read(region_addr(`ICS_REGION_STATUS, 14'h0), rd);
            check_value("status readback", rd, {30'b0, v});
            last_status = v;
        end
    endtask

    task automatic test_multiplier();
        ics_periph_pkg::bus_data_t rd;
        logic signed [15:0] a;
        logic signed [15:0] b;
        logic signed [31:0] expected;
        for (int i = 0; i < mult_iters; i++) begin
            if (i == 0) begin
                a = 16'sh8000;
                b = 16'sh8000;
            end else begin
                a = 16'($urandom);
                b = 16'($urandom);
            end
            expected = a * b;
            // word offset 0 is operand a, offset 1 is operand b
            wb_write(region_addr(`ICS_REGION_DSP, 14'h0), 4'hf, {16'h0, a});
            wb_write(region_addr(`ICS_REGION_DSP, 14'h1), 4'hf, {16'h0, b});
            wb_read(region_addr(`ICS_REGION_DSP, 14'h0), rd);
            check_value("dsp product", rd, expected);
            last_product = expected;
        end
    endtask

    task automatic test_gamepad();
        ics_periph_pkg::bus_data_t rd;
        logic [15:0] shift_model;
        btn1 = 1'($urandom);
        btn2 = 1'($urandom);
        btn3 = 1'($urandom);
        // btn1 at bit 7, btn3 at bit 6, btn2 at bit 0
        shift_model = 16'h0;
        shift_model[0] = btn2;
        shift_model[6] = btn3;
        shift_model[7] = btn1;
        wb_write(region_addr(`ICS_REGION_PAD, 14'h0), 4'hf, 32'h1);
        wb_write(region_addr(`ICS_REGION_PAD, 14'h0), 4'hf, 32'h0);
        for (int i = 0; i < pad_bits; i++) begin
            wb_read(region_addr(`ICS_REGION_PAD, 14'h0), rd);
            check_value("pad_data", rd, {31'b0, shift_model[0]});
            wb_write(region_addr(`ICS_REGION_PAD, 14'h0), 4'hf, 32'h2);
            wb_write(region_addr(`ICS_REGION_PAD, 14'h0), 4'hf, 32'h0);
            // one rising pad clock shifts right with zero fill
            shift_model = shift_model >> 1;
        end
    endtask

    task automatic test_copper();
        ics_periph_pkg::cop_addr_t addr;
        ics_periph_pkg::cop_data_t data;
        ics_periph_pkg::cop_data_t rd;
        for (int i = 0; i < cop_writes; i++) begin
            addr = 11'($urandom);
            addr[0] = i[0];
            data = 16'($urandom);
            cop_addrs[i] = addr;
            cop_model[addr] = data;
            // halfword address bit 0 picks the upper lane through sel bit 2
            wb_write(region_addr(`ICS_REGION_COP, {4'b0, addr[10:1]}),
                     addr[0] ? 4'b1100 : 4'b0011, {data, data});
        end
        for (int i = 0; i < cop_writes; i++) begin
            cop_port_read(cop_addrs[i], rd);
            check_value("cop_read_data", rd, cop_model[cop_addrs[i]]);
        end
    endtask

    task automatic test_unmapped();
        ics_periph_pkg::bus_data_t rd;
        ics_periph_pkg::cop_data_t cop_rd;
        ics_periph_pkg::cop_addr_t addr;
        wb_read(region_addr(`ICS_REGION_COP, 14'h0), rd);
        check_value("copper region read", rd, 32'h0);
        wb_read(region_addr(4'h9, 14'h0), rd);
        check_value("unmapped region read", rd, 32'h0);
        addr = cop_addrs[0];
        wb_write(region_addr(4'h9, {4'b0, addr[10:1]}), 4'hf, 32'hffff_ffff);
        wb_read(region_addr(`ICS_REGION_STATUS, 14'h0), rd);
        check_value("status after unmapped write", rd, {30'b0, last_status});
        wb_read(region_addr(`ICS_REGION_DSP, 14'h0), rd);
        check_value("product after unmapped write", rd, last_product);
        cop_port_read(addr, cop_rd);
        check_value("cop_read_data after unmapped write", cop_rd, cop_model[addr]);
    endtask

    initial begin
        void'($urandom(32'hbd3f_88f5));
        vdp_reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_sel = '0;
        wb_dat_i = '0;
        btn1 = 1'b0;
        btn2 = 1'b0;
        btn3 = 1'b0;
        cop_read_en = 1'b0;
        cop_read_address = '0;
        last_status = `ICS_STATUS_RESET;
        last_product = '0;
        repeat (reset_cycles) @(posedge vdp_clk);
        #drive_delay;
        vdp_reset = 1'b0;

        test_status();
        test_multiplier();
        test_gamepad();
        test_copper();
        test_unmapped();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hw
hw/ics_periph_pkg.sv
hw/periph_bus_ctrl.sv
hw/dsp_mult.sv
hw/pad_reader.sv
hw/cop_ram.sv
hw/ics_periph_top.sv
dv/ics_periph_tb.sv
